// File: build.f
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/dispatch_unit.sv
rtl/exec_lane.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
testbench/ooo_core_checker.sv
testbench/ooo_core_tb.sv

// File: rtl/core_ifs.sv
// cdb_if is one instance per lane; the broadcast fields are copied into every instance
interface issue_if import core_pkg::*; ();

	// dispatch to lane, one instruction per valid
	logic valid;
	opcode_t op;
	rob_tag_t tag;
	operand_t src_a;
	operand_t src_b;
	// one pulse per freed station entry
	logic credit;

	modport dispatch (
		output valid, op, tag, src_a, src_b,
		input credit
	);

	modport lane (
		input valid, op, tag, src_a, src_b,
		output credit
	);

endinterface

interface cdb_if import core_pkg::*; ();

	// lane request, held steady until grant
	logic req;
	rob_tag_t req_tag;
	word_t req_data;
	// one-hot across the lane instances
	logic grant;
	// registered broadcast, same in every instance
	logic bc_valid;
	rob_tag_t bc_tag;
	word_t bc_data;

	modport lane (
		output req, req_tag, req_data,
		input grant, bc_valid, bc_tag, bc_data
	);

	modport arbiter (
		input req, req_tag, req_data,
		output grant, bc_valid, bc_tag, bc_data
	);

	// wakeup only
	modport snoop (
		input bc_valid, bc_tag, bc_data
	);

endinterface

interface rob_if import core_pkg::*; ();

	// allocation, only while full is low
	logic alloc;
	reg_idx_t alloc_rd;
	logic full;
	rob_tag_t alloc_tag;
	// two operand read ports
	rob_tag_t read_tag_a;
	rob_tag_t read_tag_b;
	logic ready_a;
	logic ready_b;
	word_t value_a;
	word_t value_b;
	// in-order commit, no back-pressure
	logic cm_valid;
	reg_idx_t cm_rd;
	rob_tag_t cm_tag;
	word_t cm_data;

	modport dispatch (
		output alloc, alloc_rd, read_tag_a, read_tag_b,
		input full, alloc_tag, ready_a, ready_b, value_a, value_b,
		input cm_valid, cm_rd, cm_tag, cm_data
	);

	modport buffer (
		input alloc, alloc_rd, read_tag_a, read_tag_b,
		output full, alloc_tag, ready_a, ready_b, value_a, value_b,
		output cm_valid, cm_rd, cm_tag, cm_data
	);

endinterface

// File: rtl/core_pkg.sv
// sizes are fixed here for the whole core; depths must stay powers of two so pointers wrap
package core_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	// architectural registers, all writable
	localparam int NUM_REGS = 16;
	localparam int ROB_DEPTH = 8;
	localparam int NUM_LANES = 2;
	// station entries per lane, also the lane credit count
	localparam int RS_DEPTH = 2;
	// input queue entries, also the upstream credit count
	localparam int IQ_DEPTH = 4;

	// derived widths
	localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
	localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);
	localparam int RS_IDX_W = $clog2(RS_DEPTH);
	localparam int RS_CNT_W = $clog2(RS_DEPTH + 1);
	localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

	// op_li takes imm, op_sll uses the low five bits of b
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_li
	} opcode_t;

	// tag only meaningful while ready is low
	typedef struct packed {
		word_t value;
		logic ready;
		rob_tag_t tag;
	} operand_t;

	typedef enum logic [1:0] {
		rs_free,
		rs_waiting,
		rs_ready
	} rs_state_t;

endpackage

// File: rtl/dispatch_unit.sv
// upstream may send only while holding a credit; the queue does not guard against overflow
module dispatch_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input opcode_t op,
	input reg_idx_t rd,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	input word_t imm,
	output logic inst_credit,
	issue_if.dispatch lanes [NUM_LANES],
	rob_if.dispatch rob,
	cdb_if.snoop cdb
);

	typedef struct packed {
		opcode_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm;
	} iq_entry_t;

	iq_entry_t iq_mem [IQ_DEPTH];
	iq_entry_t iq_head;
	logic [IQ_PTR_W-1:0] iq_wr_ptr;
	logic [IQ_PTR_W-1:0] iq_rd_ptr;
	logic [IQ_CNT_W-1:0] iq_count;

	word_t reg_file [NUM_REGS];
	// register waits on tag_tbl entry while busy
	logic [NUM_REGS-1:0] busy;
	rob_tag_t tag_tbl [NUM_REGS];

	logic [RS_CNT_W-1:0] lane_credits [NUM_LANES];
	logic [NUM_LANES-1:0] lane_avail;
	logic [NUM_LANES-1:0] lane_pick;
	logic [NUM_LANES-1:0] lane_send;
	logic [NUM_LANES-1:0] lane_credit_ret;
	logic fire;
	operand_t opnd_a;
	operand_t opnd_b;

	//////////////////////////////////////////////////
	// operand resolution
	//////////////////////////////////////////////////

	// bypass, regfile, rob port, broadcast, then wait on tag
	function automatic operand_t resolve(input reg_idx_t r, input logic port_ready,
			input word_t port_value);
		operand_t o;
		o.value = '0;
		o.ready = 1'b1;
		o.tag = tag_tbl[r];
		if (rob.cm_valid && busy[r] && rob.cm_rd == r && rob.cm_tag == tag_tbl[r]) begin
			o.value = rob.cm_data;
		end else if (!busy[r]) begin
			o.value = reg_file[r];
		end else if (port_ready) begin
			o.value = port_value;
		end else if (cdb.bc_valid && cdb.bc_tag == tag_tbl[r]) begin
			o.value = cdb.bc_data;
		end else begin
			o.ready = 1'b0;
		end
		return o;
	endfunction

	assign iq_head = iq_mem[iq_rd_ptr];
	assign rob.read_tag_a = tag_tbl[iq_head.rs1];
	assign rob.read_tag_b = tag_tbl[iq_head.rs2];

	always_comb begin
		opnd_a = resolve(iq_head.rs1, rob.ready_a, rob.value_a);
		opnd_b = resolve(iq_head.rs2, rob.ready_b, rob.value_b);
		// li needs no registers
		if (iq_head.op == op_li) begin
			opnd_a = '{value: iq_head.imm, ready: 1'b1, tag: '0};
			opnd_b = '{value: iq_head.imm, ready: 1'b1, tag: '0};
		end
	end

	//////////////////////////////////////////////////
	// lane steering
	//////////////////////////////////////////////////

	// lowest lane with credit wins
	always_comb begin
		lane_pick = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (lane_avail[i]) begin
				lane_pick = '0;
				lane_pick[i] = 1'b1;
			end
		end
	end

	assign fire = (iq_count != '0) && !rob.full && (|lane_avail);
	assign lane_send = fire ? lane_pick : '0;
	assign rob.alloc = fire;
	assign rob.alloc_rd = iq_head.rd;

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane_io
		assign lanes[g].valid = lane_send[g];
		assign lanes[g].op = iq_head.op;
		// rd renamed to the tail tag
		assign lanes[g].tag = rob.alloc_tag;
		assign lanes[g].src_a = opnd_a;
		assign lanes[g].src_b = opnd_b;
		assign lane_credit_ret[g] = lanes[g].credit;
		assign lane_avail[g] = lane_credits[g] != '0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				lane_credits[i] <= RS_CNT_W'(RS_DEPTH);
			end
		end else begin
			// send and return together leave the count alone
			for (int i = 0; i < NUM_LANES; i++) begin
				if (lane_send[i] && !lane_credit_ret[i]) begin
					lane_credits[i] <= lane_credits[i] - 1'b1;
				end else if (!lane_send[i] && lane_credit_ret[i]) begin
					lane_credits[i] <= lane_credits[i] + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// input queue and architectural state
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			iq_mem[iq_wr_ptr] <= '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
		end
		if (fire) begin
			tag_tbl[iq_head.rd] <= rob.alloc_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			iq_wr_ptr <= '0;
			iq_rd_ptr <= '0;
			iq_count <= '0;
			inst_credit <= 1'b0;
		end else begin
			if (inst_valid) begin
				iq_wr_ptr <= iq_wr_ptr + 1'b1;
			end
			if (fire) begin
				iq_rd_ptr <= iq_rd_ptr + 1'b1;
			end
			iq_count <= iq_count + IQ_CNT_W'(inst_valid) - IQ_CNT_W'(fire);
			// credit pulse one cycle after leaving
			inst_credit <= fire;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				reg_file[i] <= '0;
			end
			busy <= '0;
		end else begin
			if (rob.cm_valid) begin
				reg_file[rob.cm_rd] <= rob.cm_data;
				// younger writer keeps the register busy
				if (tag_tbl[rob.cm_rd] == rob.cm_tag) begin
					busy[rob.cm_rd] <= 1'b0;
				end
			end
			// new rename overrides the clear
			if (fire) begin
				busy[iq_head.rd] <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/exec_lane.sv
// one result in flight per lane; its station entry stays held until the bus grant
module exec_lane import core_pkg::*; (
	input logic clock,
	input logic reset,
	issue_if.lane issue,
	cdb_if.lane cdb
);

	rs_state_t state [RS_DEPTH];
	opcode_t ent_op [RS_DEPTH];
	rob_tag_t ent_tag [RS_DEPTH];
	operand_t ent_a [RS_DEPTH];
	operand_t ent_b [RS_DEPTH];
	// operands after this cycle's broadcast
	operand_t wake_a [RS_DEPTH];
	operand_t wake_b [RS_DEPTH];

	logic [RS_IDX_W-1:0] alloc_slot;
	logic [RS_IDX_W-1:0] exec_slot;
	logic exec_go;
	logic res_valid;
	logic [RS_IDX_W-1:0] res_slot;
	rob_tag_t res_tag;
	word_t res_data;

	function automatic operand_t wake(input operand_t o);
		operand_t w;
		w = o;
		if (!o.ready && cdb.bc_valid && cdb.bc_tag == o.tag) begin
			w.value = cdb.bc_data;
			w.ready = 1'b1;
		end
		return w;
	endfunction

	function automatic word_t alu(input opcode_t f, input word_t a, input word_t b);
		case (f)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_sll: return a << b[4:0];
			op_li: return b;
			default: return '0;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// slot select
	//////////////////////////////////////////////////

	always_comb begin
		alloc_slot = '0;
		exec_slot = '0;
		exec_go = 1'b0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			wake_a[i] = wake(ent_a[i]);
			wake_b[i] = wake(ent_b[i]);
			if (state[i] == rs_free) begin
				alloc_slot = RS_IDX_W'(i);
			end
			// skip the entry whose result is still on the bus
			if (state[i] == rs_ready && !(res_valid && res_slot == RS_IDX_W'(i))) begin
				exec_slot = RS_IDX_W'(i);
				exec_go = 1'b1;
			end
		end
		// result reg free now or freed by grant
		exec_go = exec_go && (!res_valid || cdb.grant);
	end

	//////////////////////////////////////////////////
	// station and result register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				state[i] <= rs_free;
			end
			res_valid <= 1'b0;
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (state[i] == rs_waiting && wake_a[i].ready && wake_b[i].ready) begin
					state[i] <= rs_ready;
				end
			end
			if (cdb.grant) begin
				state[res_slot] <= rs_free;
			end
			if (issue.valid) begin
				state[alloc_slot] <= (issue.src_a.ready && issue.src_b.ready) ?
					rs_ready : rs_waiting;
			end
			if (exec_go) begin
				res_valid <= 1'b1;
			end else if (cdb.grant) begin
				res_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			ent_a[i] <= wake_a[i];
			ent_b[i] <= wake_b[i];
		end
		if (issue.valid) begin
			ent_op[alloc_slot] <= issue.op;
			ent_tag[alloc_slot] <= issue.tag;
			ent_a[alloc_slot] <= issue.src_a;
			ent_b[alloc_slot] <= issue.src_b;
		end
		if (exec_go) begin
			res_slot <= exec_slot;
			res_tag <= ent_tag[exec_slot];
			res_data <= alu(ent_op[exec_slot], ent_a[exec_slot].value, ent_b[exec_slot].value);
		end
	end

	// request held until granted
	assign cdb.req = res_valid;
	assign cdb.req_tag = res_tag;
	assign cdb.req_data = res_data;
	// entry freed on grant, so credit goes back with it
	assign issue.credit = cdb.grant;

endmodule

// File: rtl/ooo_core.sv
// commit outputs carry no back-pressure; the source must track inst_credit, IQ_DEPTH at reset
module ooo_core import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input opcode_t op,
	input reg_idx_t rd,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	input word_t imm,
	output logic inst_credit,
	output logic commit_valid,
	output reg_idx_t commit_rd,
	output word_t commit_data
);

	// per lane issue and bus links
	issue_if issue_bus [NUM_LANES] ();
	cdb_if cdb_bus [NUM_LANES] ();
	rob_if rob_bus ();

	//////////////////////////////////////////////////
	// front end
	//////////////////////////////////////////////////

	// snoops lane 0's copy, the broadcast is the same everywhere
	dispatch_unit u_dispatch (
		.clock (clock),
		.reset (reset),
		.inst_valid (inst_valid),
		.op (op),
		.rd (rd),
		.rs1 (rs1),
		.rs2 (rs2),
		.imm (imm),
		.inst_credit (inst_credit),
		.lanes (issue_bus),
		.rob (rob_bus),
		.cdb (cdb_bus[0])
	);

	//////////////////////////////////////////////////
	// execution lanes
	//////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		exec_lane u_lane (
			.clock (clock),
			.reset (reset),
			.issue (issue_bus[g]),
			.cdb (cdb_bus[g])
		);
	end

	reorder_buffer u_rob (
		.clock (clock),
		.reset (reset),
		.rob (rob_bus),
		.cdb (cdb_bus)
	);

	// commit port to the outside
	assign commit_valid = rob_bus.cm_valid;
	assign commit_rd = rob_bus.cm_rd;
	assign commit_data = rob_bus.cm_data;

endmodule

// File: rtl/reorder_buffer.sv
// fixed priority bus grant, lane 0 first; a starved upper lane is possible under constant load
module reorder_buffer import core_pkg::*; (
	input logic clock,
	input logic reset,
	rob_if.buffer rob,
	cdb_if.arbiter cdb [NUM_LANES]
);

	reg_idx_t ent_rd [ROB_DEPTH];
	word_t ent_value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ent_ready;
	rob_tag_t head;
	rob_tag_t tail;
	logic [ROB_CNT_W-1:0] count;
	logic head_go;

	logic [NUM_LANES-1:0] req;
	logic [NUM_LANES-1:0] grant;
	rob_tag_t req_tag [NUM_LANES];
	word_t req_data [NUM_LANES];
	rob_tag_t win_tag;
	word_t win_data;
	logic bc_valid;
	rob_tag_t bc_tag;
	word_t bc_data;

	//////////////////////////////////////////////////
	// data bus arbitration
	//////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_cdb
		assign req[g] = cdb[g].req;
		assign req_tag[g] = cdb[g].req_tag;
		assign req_data[g] = cdb[g].req_data;
		assign cdb[g].grant = grant[g];
		// broadcast fanned out to every lane copy
		assign cdb[g].bc_valid = bc_valid;
		assign cdb[g].bc_tag = bc_tag;
		assign cdb[g].bc_data = bc_data;
	end

	always_comb begin
		grant = '0;
		win_tag = '0;
		win_data = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (req[i]) begin
				grant = '0;
				grant[i] = 1'b1;
				win_tag = req_tag[i];
				win_data = req_data[i];
			end
		end
	end

	//////////////////////////////////////////////////
	// allocation, capture and commit
	//////////////////////////////////////////////////

	assign rob.full = count == ROB_CNT_W'(ROB_DEPTH);
	assign rob.alloc_tag = tail;
	assign rob.ready_a = ent_ready[rob.read_tag_a];
	assign rob.value_a = ent_value[rob.read_tag_a];
	assign rob.ready_b = ent_ready[rob.read_tag_b];
	assign rob.value_b = ent_value[rob.read_tag_b];
	assign head_go = (count != '0) && ent_ready[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			ent_ready <= '0;
			bc_valid <= 1'b0;
			rob.cm_valid <= 1'b0;
		end else begin
			// broadcast one cycle after grant
			bc_valid <= |req;
			if (bc_valid) begin
				ent_ready[bc_tag] <= 1'b1;
			end
			if (rob.alloc) begin
				ent_ready[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (head_go) begin
				ent_ready[head] <= 1'b0;
				head <= head + 1'b1;
			end
			count <= count + ROB_CNT_W'(rob.alloc) - ROB_CNT_W'(head_go);
			rob.cm_valid <= head_go;
		end
	end

	always_ff @(posedge clock) begin
		if (|req) begin
			bc_tag <= win_tag;
			bc_data <= win_data;
		end
		if (bc_valid) begin
			ent_value[bc_tag] <= bc_data;
		end
		if (rob.alloc) begin
			ent_rd[tail] <= rob.alloc_rd;
		end
		// commit payload follows the head
		if (head_go) begin
			rob.cm_rd <= ent_rd[head];
			rob.cm_tag <= head;
			rob.cm_data <= ent_value[head];
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator; passes only if the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module ooo_core_tb \
	-o ooo_core_sim \
	&& ./obj_dir/ooo_core_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

// File: testbench/ooo_core_checker.sv
// bound into ooo_core; grant, request and queue count are reached through the bind connections
module ooo_core_checker import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input logic inst_credit,
	input logic commit_valid,
	input logic [NUM_LANES-1:0] req,
	input logic [NUM_LANES-1:0] grant,
	input logic [IQ_CNT_W-1:0] iq_count
);

	timeunit 1ns;
	timeprecision 1ns;

	// failed assertions so far
	int failures = 0;

	//////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////

	// at most one lane on the bus, only a requesting one, and never idle under a request
	assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant) && ((grant & ~req) == '0) && ((|req) == (|grant)))
	else begin
		failures++;
		$error("data bus grant not one-hot on a requesting lane");
	end

	// source must not overrun the queue
	assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> iq_count != IQ_CNT_W'(IQ_DEPTH))
	else begin
		failures++;
		$error("instruction sent while the input queue was full");
	end

	// outputs quiet once reset has been seen
	assert property (@(posedge clock) $past(reset) && reset |-> !commit_valid && !inst_credit)
	else begin
		failures++;
		$error("commit_valid or inst_credit high during reset");
	end

endmodule

bind ooo_core ooo_core_checker u_checker (
	.clock (clock),
	.reset (reset),
	.inst_valid (inst_valid),
	.inst_credit (inst_credit),
	.commit_valid (commit_valid),
	.req (u_rob.req),
	.grant (u_rob.grant),
	.iq_count (u_dispatch.iq_count)
);

// File: testbench/ooo_core_tb.sv
// source side keeps its own credit count; expected commits assume all registers start at zero
module ooo_core_tb import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int NUM_ROWS = 24;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	// thirty cycles of slack per row
	localparam int TIMEOUT_NS = NUM_ROWS * 30 * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h1d89cb2e;

	typedef struct {
		opcode_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm;
		word_t result;
	} row_t;

	logic clock = 1'b0;
	logic reset;
	logic inst_valid;
	opcode_t op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t imm;
	logic inst_credit;
	logic commit_valid;
	reg_idx_t commit_rd;
	word_t commit_data;

	row_t rows [NUM_ROWS];
	int sent = 0;
	int pulses = 0;
	int commits = 0;
	int mismatches = 0;
	int other_errors = 0;

	ooo_core uut (
		.clock (clock),
		.reset (reset),
		.inst_valid (inst_valid),
		.op (op),
		.rd (rd),
		.rs1 (rs1),
		.rs2 (rs2),
		.imm (imm),
		.inst_credit (inst_credit),
		.commit_valid (commit_valid),
		.commit_rd (commit_rd),
		.commit_data (commit_data)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////
	// stimulus rows
	//////////////////////////////////////////////////

	task automatic put_row(input int i, input opcode_t o, input reg_idx_t d, input reg_idx_t a,
			input reg_idx_t b, input word_t im, input word_t res);
		rows[i] = '{op: o, rd: d, rs1: a, rs2: b, imm: im, result: res};
	endtask

	task automatic load_rows();
		// immediates first
		put_row(0, op_li, 4'd1, 4'd0, 4'd0, 32'h5, 32'h5);
		put_row(1, op_li, 4'd2, 4'd0, 4'd0, 32'h3, 32'h3);
		put_row(2, op_li, 4'd3, 4'd0, 4'd0, 32'h10, 32'h10);
		// dependent chain on r4
		put_row(3, op_add, 4'd4, 4'd1, 4'd2, 32'h0, 32'h8);
		put_row(4, op_add, 4'd4, 4'd4, 4'd1, 32'h0, 32'hd);
		put_row(5, op_sub, 4'd4, 4'd4, 4'd2, 32'h0, 32'ha);
		put_row(6, op_add, 4'd5, 4'd4, 4'd4, 32'h0, 32'h14);
		// independent ops, spread over lanes
		put_row(7, op_xor, 4'd6, 4'd5, 4'd3, 32'h0, 32'h4);
		put_row(8, op_and, 4'd7, 4'd5, 4'd1, 32'h0, 32'h4);
		put_row(9, op_or, 4'd8, 4'd3, 4'd2, 32'h0, 32'h13);
		put_row(10, op_sll, 4'd9, 4'd2, 4'd2, 32'h0, 32'h18);
		put_row(11, op_li, 4'd10, 4'd0, 4'd0, 32'hdeadbeef, 32'hdeadbeef);
		put_row(12, op_add, 4'd11, 4'd10, 4'd0, 32'h0, 32'hdeadbeef);
		// r12 written twice, readers around the second write
		put_row(13, op_li, 4'd12, 4'd0, 4'd0, 32'h7, 32'h7);
		put_row(14, op_add, 4'd13, 4'd12, 4'd1, 32'h0, 32'hc);
		put_row(15, op_li, 4'd12, 4'd0, 4'd0, 32'h100, 32'h100);
		put_row(16, op_add, 4'd14, 4'd12, 4'd1, 32'h0, 32'h105);
		put_row(17, op_sub, 4'd15, 4'd0, 4'd1, 32'h0, 32'hfffffffb);
		put_row(18, op_sll, 4'd15, 4'd15, 4'd2, 32'h0, 32'hffffffd8);
		// r0 is an ordinary register here
		put_row(19, op_xor, 4'd0, 4'd10, 4'd15, 32'h0, 32'h21524137);
		put_row(20, op_and, 4'd1, 4'd0, 4'd10, 32'h0, 32'h27);
		put_row(21, op_or, 4'd2, 4'd1, 4'd3, 32'h0, 32'h37);
		put_row(22, op_li, 4'd5, 4'd0, 4'd0, 32'h1, 32'h1);
		put_row(23, op_sll, 4'd6, 4'd2, 4'd5, 32'h0, 32'h6e);
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_rd(input int row, input reg_idx_t expected, input reg_idx_t actual);
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch commit_rd row %0d: expected 0x%h, got 0x%h", row, expected, actual);
		end
	endtask

	task automatic check_data(input int row, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch commit_data row %0d: expected 0x%h, got 0x%h", row, expected,
				actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			mismatches++;
			$display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// monitor, sampled mid cycle
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset && inst_credit) begin
			pulses++;
		end
		if (!reset && commit_valid) begin
			if (commits >= sent) begin
				other_errors++;
				$display("commit seen with no instruction outstanding");
			end else begin
				check_rd(commits, rows[commits].rd, commit_rd);
				check_data(commits, rows[commits].result, commit_data);
			end
			commits++;
		end
		// a pulse with nothing sent hands out a credit the queue lacks
		if (pulses > sent) begin
			other_errors++;
			$display("inst_credit pulsed with no instruction sent");
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int gap;
		void'($urandom(SEED));
		reset = 1'b1;
		inst_valid = 1'b0;
		op = op_add;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		load_rows();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			// hold off until a credit is back
			while (IQ_DEPTH - sent + pulses <= 0) begin
				inst_valid <= 1'b0;
				@(posedge clock);
			end
			inst_valid <= 1'b1;
			op <= rows[i].op;
			rd <= rows[i].rd;
			rs1 <= rows[i].rs1;
			rs2 <= rows[i].rs2;
			imm <= rows[i].imm;
			sent++;
			gap = $urandom % 3;
			@(posedge clock);
			if (gap > 0) begin
				inst_valid <= 1'b0;
				repeat (gap) @(posedge clock);
			end
		end
		inst_valid <= 1'b0;
		wait (commits == NUM_ROWS);
		repeat (4) @(posedge clock);
		check_count("inst_credit pulses", sent, pulses);
		other_errors += uut.u_checker.failures;
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: only %0d of %0d rows committed", commits, NUM_ROWS);
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
